//--- Makefile
# Verilator build and run for the operand-delivery pipeline

VERILATOR ?= verilator
TOP       ?= tb_pipe_core
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_STR  ?= Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_STR)$$"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tb_pipe_core.sv
// testbench for pipe_core
// clock, memory model, LCG stimulus, in-order reference model
// writeback and store checkers, watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_pipe_core;

    localparam int n_indep = 20;
    localparam int n_dep   = 24;
    localparam int n_load  = 24;
    localparam int n_csr   = 16;
    localparam int n_rand  = 120;
    localparam int total_insts = n_indep + n_dep + n_load + n_csr + n_rand + 5 * 5;

    logic                           clk = 1'b0;
    logic                           rst;
    logic                           inst_valid;
    pipe_pkg::op_t                  inst_op;
    logic [pipe_pkg::reg_idx_w-1:0] inst_rd, inst_rs1, inst_rs2;
    logic [pipe_pkg::csr_idx_w-1:0] inst_csr;
    logic [pipe_pkg::xlen-1:0]      inst_imm, mem_rdata, mem_addr, mem_wdata, wb_data;
    logic                           mem_rvalid, mem_wready, stall, mem_we, wb_valid;
    logic [pipe_pkg::reg_idx_w-1:0] wb_rd;

    logic [pipe_pkg::xlen-1:0] mem [16];
    logic [pipe_pkg::xlen-1:0] sh_mem [16];
    logic [pipe_pkg::xlen-1:0] sh_gpr [32];
    logic [pipe_pkg::xlen-1:0] sh_csr [4];

    logic [pipe_pkg::reg_idx_w-1:0] exp_rd_q [$];
    logic [pipe_pkg::xlen-1:0]      exp_val_q [$];
    int                             exp_cyc_q [$];
    logic [pipe_pkg::xlen-1:0]      st_addr_q [$];
    logic [pipe_pkg::xlen-1:0]      st_data_q [$];

    logic [31:0] lcg_state = 32'd35002;
    int    cyc = 0;
    int    errors = 0;
    int    checks = 0;
    int    tests_run = 0;
    int    tests_bad = 0;
    string cur_test = "reset";
    logic  gaps = 1'b0;

    pipe_core dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (mem_we && mem_wready && !stall) begin
            mem[mem_addr[5:2]] <= mem_wdata;
        end
    end

    // memory answers combinationally
    assign mem_rdata = mem[mem_addr[5:2]];

    function automatic int lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'({16'b0, lcg_state[31:16]});
    endfunction

    function automatic int rnd(input int n);
        return lcg_next() % n;
    endfunction

    // ==============================
    // reference model
    // ==============================

    function automatic void ref_exec(input pipe_pkg::op_t op,
                                     input logic [pipe_pkg::reg_idx_w-1:0] rd, rs1, rs2,
                                     input logic [pipe_pkg::csr_idx_w-1:0] csr,
                                     input logic [pipe_pkg::xlen-1:0] imm);
        logic [pipe_pkg::xlen-1:0] a, b, res, addr;
        logic                      wr;
        a    = sh_gpr[rs1];
        b    = sh_gpr[rs2];
        addr = a + imm;
        res  = '0;
        wr   = 1'b1;
        case (op)
            pipe_pkg::op_add:  res = a + b;
            pipe_pkg::op_sub:  res = a - b;
            pipe_pkg::op_addi: res = a + imm;
            pipe_pkg::op_and:  res = a & b;
            pipe_pkg::op_or:   res = a | b;
            pipe_pkg::op_xor:  res = a ^ b;
            pipe_pkg::op_lw:   res = sh_mem[addr[5:2]];
            pipe_pkg::op_sw: begin
                sh_mem[addr[5:2]] = b;
                st_addr_q.push_back(addr);
                st_data_q.push_back(b);
                wr = 1'b0;
            end
            pipe_pkg::op_csrrw: begin
                res = sh_csr[csr];
                sh_csr[csr] = a;
            end
            default: wr = 1'b0;
        endcase
        if (wr && rd != '0) begin
            sh_gpr[rd] = res;
            exp_rd_q.push_back(rd);
            exp_val_q.push_back(res);
            exp_cyc_q.push_back(cyc);
        end
    endfunction

    // ==============================
    // compare tasks and checker
    // ==============================

    task automatic check_wb(input logic [pipe_pkg::reg_idx_w-1:0] exp_rd, act_rd,
                            input logic [pipe_pkg::xlen-1:0] exp_val, act_val);
        checks++;
        if (exp_rd !== act_rd || exp_val !== act_val) begin
            errors++;
            $display("[FAIL] %s wb expected x%0d=%h actual x%0d=%h",
                     cur_test, exp_rd, exp_val, act_rd, act_val);
        end
    endtask

    task automatic check_store(input logic [pipe_pkg::xlen-1:0] exp_addr, act_addr,
                               input logic [pipe_pkg::xlen-1:0] exp_data, act_data);
        checks++;
        if (exp_addr !== act_addr || exp_data !== act_data) begin
            errors++;
            $display("[FAIL] %s store expected [%h]=%h actual [%h]=%h",
                     cur_test, exp_addr, exp_data, act_addr, act_data);
        end
    endtask

    task automatic check_stall(input logic exp_stall, act_stall);
        checks++;
        if (exp_stall !== act_stall) begin
            errors++;
            $display("[FAIL] %s stall expected %b actual %b", cur_test, exp_stall, act_stall);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("%s: %s", cur_test, what);
    endtask

    always @(negedge clk) begin
        // stall is high whenever any readiness input is low
        check_stall(!(inst_valid && mem_rvalid && mem_wready), stall);
        if (rst || cur_test == "reset") begin
            checks++;
            if (wb_valid || mem_we) report_error("writeback or store active before any instruction");
        end else begin
            if (wb_valid) begin
                if (wb_rd == '0) report_error("writeback to x0");
                if (exp_rd_q.size() == 0) begin
                    report_error("unexpected writeback with nothing outstanding");
                end else begin
                    // gap-free streams retire exactly three edges after acceptance
                    if (!gaps && cyc - exp_cyc_q[0] != 3) begin
                        report_error($sformatf("writeback latency %0d cycles, 3 expected",
                                               cyc - exp_cyc_q[0]));
                    end
                    void'(exp_cyc_q.pop_front());
                    check_wb(exp_rd_q.pop_front(), wb_rd, exp_val_q.pop_front(), wb_data);
                end
            end
            if (mem_we && mem_wready && !stall) begin
                if (st_addr_q.size() == 0) begin
                    report_error("unexpected store with nothing outstanding");
                end else begin
                    check_store(st_addr_q.pop_front(), mem_addr, st_data_q.pop_front(),
                                mem_wdata);
                end
            end
        end
    end

    // ==============================
    // stimulus
    // ==============================

    // holds the instruction until an edge accepts it
    task automatic send_inst(input pipe_pkg::op_t op,
                             input logic [pipe_pkg::reg_idx_w-1:0] rd, rs1, rs2,
                             input logic [pipe_pkg::csr_idx_w-1:0] csr,
                             input logic [pipe_pkg::xlen-1:0] imm);
        logic accepted;
        accepted = 1'b0;
        while (!accepted) begin
            inst_op    = op;
            inst_rd    = rd;
            inst_rs1   = rs1;
            inst_rs2   = rs2;
            inst_csr   = csr;
            inst_imm   = imm;
            inst_valid = gaps ? (rnd(8) != 0) : 1'b1;
            mem_rvalid = gaps ? (rnd(8) != 0) : 1'b1;
            mem_wready = gaps ? (rnd(8) != 0) : 1'b1;
            accepted   = inst_valid & mem_rvalid & mem_wready;
            // model runs in the cycle the instruction is presented
            if (accepted) ref_exec(op, rd, rs1, rs2, csr, imm);
            @(posedge clk);
            #2;
        end
    endtask

    task automatic run_test(input string name, input int kind, input int n);
        int err0;
        pipe_pkg::op_t op;
        logic [pipe_pkg::reg_idx_w-1:0] rd, rs1, rs2;
        logic [pipe_pkg::reg_idx_w-1:0] hist [3];
        logic [pipe_pkg::csr_idx_w-1:0] csr;
        logic [pipe_pkg::xlen-1:0] imm;
        err0     = errors;
        cur_test = name;
        gaps     = (kind == 5);
        hist     = '{5'd1, 5'd2, 5'd3};
        for (int i = 0; i < n; i++) begin
            rd  = 5'(1 + rnd(7));
            rs1 = 5'(1 + rnd(7));
            rs2 = 5'(1 + rnd(7));
            csr = 2'(rnd(4));
            imm = 32'(lcg_next());
            op  = pipe_pkg::op_t'(4'(1 + rnd(6)));
            case (kind)
                1: begin
                    // sources last written four or more instructions back
                    rd  = 5'(1 + i % 7);
                    rs1 = 5'(1 + (i + 2) % 7);
                    rs2 = 5'(1 + (i + 3) % 7);
                end
                2: begin
                    rs1 = hist[0];
                    rs2 = (i % 2 == 1) ? hist[1] : hist[2];
                end
                3: begin
                    if (i % 2 == 0) begin
                        op  = pipe_pkg::op_lw;
                        imm = 32'(rnd(16) * 4);
                    end else if (i % 4 == 1) begin
                        op  = pipe_pkg::op_add;
                        rs1 = hist[0];
                        rs2 = hist[0];
                    end else begin
                        op  = pipe_pkg::op_sw;
                        rs2 = hist[0];
                        imm = 32'(rnd(16) * 4);
                    end
                end
                4: begin
                    op  = (i % 4 == 3) ? pipe_pkg::op_addi : pipe_pkg::op_csrrw;
                    csr = (i < n / 2) ? 2'd1 : 2'd2;
                    if (i % 2 == 1) rs1 = hist[0];
                end
                default: begin
                    op = pipe_pkg::op_t'(4'(rnd(10)));
                    rd = 5'(rnd(8));
                    if (op == pipe_pkg::op_lw || op == pipe_pkg::op_sw) imm = 32'(rnd(16) * 4);
                end
            endcase
            send_inst(op, rd, rs1, rs2, csr, imm);
            if (op != pipe_pkg::op_sw && op != pipe_pkg::op_nop) begin
                hist = '{rd, hist[0], hist[1]};
            end
        end
        repeat (5) send_inst(pipe_pkg::op_nop, '0, '0, '0, '0, '0);
        inst_valid = 1'b0;
        mem_rvalid = 1'b1;
        mem_wready = 1'b1;
        @(negedge clk);
        if (exp_rd_q.size() != 0 || st_addr_q.size() != 0) begin
            report_error("expected writebacks or stores never appeared");
        end
        @(posedge clk);
        #2;
        tests_run++;
        if (errors != err0) tests_bad++;
        $display("test %s: %0s, %0d errors", name, (errors == err0) ? "ok" : "bad",
                 errors - err0);
    endtask

    initial begin
        for (int i = 0; i < 16; i++) begin
            mem[i]    = 32'h5a00_0000 ^ (32'(i) * 32'h0101_0111);
            sh_mem[i] = 32'h5a00_0000 ^ (32'(i) * 32'h0101_0111);
        end
        for (int i = 0; i < 32; i++) sh_gpr[i] = '0;
        for (int i = 0; i < 4; i++) sh_csr[i] = '0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst_op    = pipe_pkg::op_nop;
        inst_rd    = '0;
        inst_rs1   = '0;
        inst_rs2   = '0;
        inst_csr   = '0;
        inst_imm   = '0;
        mem_rvalid = 1'b1;
        mem_wready = 1'b1;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        // idle cycles, nothing may retire yet
        repeat (3) @(posedge clk);
        #2;
        tests_run++;
        if (errors != 0) tests_bad++;
        $display("test reset: %0s, %0d errors", (errors == 0) ? "ok" : "bad", errors);
        run_test("independent", 1, n_indep);
        run_test("dependent", 2, n_dep);
        run_test("load_use", 3, n_load);
        run_test("csr_chain", 4, n_csr);
        run_test("random_gaps", 5, n_rand);
        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(3 * total_insts * 40 + 10 * 40 + 3 * 40);
        $display("watchdog expired, the pipeline hung in test %s", cur_test);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
src/pipe_pkg.sv
src/stage_reg.sv
src/forward_unit.sv
src/arch_regs.sv
src/exec_alu.sv
src/pipe_core.sv
dv/tb_pipe_core.sv

//--- src/arch_regs.sv
// general register file (32 x xlen) and CSR file (4 x xlen)
// asynchronous reads, synchronous writes, x0 reads zero
`timescale 1ns/1ns
`default_nettype none

module arch_regs (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic [pipe_pkg::reg_idx_w-1:0]    rs1,
    input  wire logic [pipe_pkg::reg_idx_w-1:0]    rs2,
    input  wire logic [pipe_pkg::csr_idx_w-1:0]    csr_rd_idx,
    input  wire logic                              we_gpr,
    input  wire logic [pipe_pkg::reg_idx_w-1:0]    wd_idx,
    input  wire logic [pipe_pkg::xlen-1:0]         wd_gpr,
    input  wire logic                              we_csr,
    input  wire logic [pipe_pkg::csr_idx_w-1:0]    wc_idx,
    input  wire logic [pipe_pkg::xlen-1:0]         wd_csr,
    output logic [pipe_pkg::xlen-1:0]              rs1_val,
    output logic [pipe_pkg::xlen-1:0]              rs2_val,
    output logic [pipe_pkg::xlen-1:0]              csr_val
);

    logic [pipe_pkg::xlen-1:0] gpr [2**pipe_pkg::reg_idx_w];
    logic [pipe_pkg::xlen-1:0] csr [2**pipe_pkg::csr_idx_w];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**pipe_pkg::reg_idx_w; i++) begin
                gpr[i] <= '0;
            end
            for (int i = 0; i < 2**pipe_pkg::csr_idx_w; i++) begin
                csr[i] <= '0;
            end
        end else begin
            if (we_gpr) begin
                gpr[wd_idx] <= wd_gpr;
            end
            if (we_csr) begin
                csr[wc_idx] <= wd_csr;
            end
        end
    end

    // same-cycle write/read overlap is resolved by the forwarding unit
    assign rs1_val = (rs1 == '0) ? '0 : gpr[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : gpr[rs2];
    assign csr_val = csr[csr_rd_idx];

endmodule

`default_nettype wire

//--- src/exec_alu.sv
// execute-stage datapath
// register ops, immediate add for addi and address generation, CSR exchange
`timescale 1ns/1ns
`default_nettype none

module exec_alu (
    input  wire pipe_pkg::op_t             op,
    input  wire logic [pipe_pkg::xlen-1:0] a,
    input  wire logic [pipe_pkg::xlen-1:0] b,
    input  wire logic [pipe_pkg::xlen-1:0] imm,
    input  wire logic [pipe_pkg::xlen-1:0] csr_in,
    output logic [pipe_pkg::xlen-1:0]      alu_out,
    output logic [pipe_pkg::xlen-1:0]      csr_out
);

    always_comb begin
        case (op)
            pipe_pkg::op_add: alu_out = a + b;
            pipe_pkg::op_sub: alu_out = a - b;
            pipe_pkg::op_and: alu_out = a & b;
            pipe_pkg::op_or:  alu_out = a | b;
            pipe_pkg::op_xor: alu_out = a ^ b;
            // addi result or load/store address
            pipe_pkg::op_addi,
            pipe_pkg::op_lw,
            pipe_pkg::op_sw:  alu_out = a + imm;
            // csrrw returns the old CSR value to rd
            pipe_pkg::op_csrrw: alu_out = csr_in;
            default: alu_out = '0;
        endcase
    end

    // new CSR value, only committed when write_csr is set
    assign csr_out = a;

endmodule

`default_nettype wire

//--- src/forward_unit.sv
// hazard classification and operand forwarding
// execute-stage and decode-stage forward selects and data
// whole-pipeline stall and writeback-slot flush
`timescale 1ns/1ns
`default_nettype none

module forward_unit (
    // all three high means the stage's accesses are done
    input  wire logic                              inst_valid,
    input  wire logic                              mem_rvalid,
    input  wire logic                              mem_wready,
    // decode sources
    input  wire logic [pipe_pkg::reg_idx_w-1:0]    id_rs1,
    input  wire logic [pipe_pkg::reg_idx_w-1:0]    id_rs2,
    input  wire logic [pipe_pkg::csr_idx_w-1:0]    id_csr,
    // execute sources
    input  wire logic [pipe_pkg::reg_idx_w-1:0]    ex_rs1,
    input  wire logic [pipe_pkg::reg_idx_w-1:0]    ex_rs2,
    input  wire logic [pipe_pkg::csr_idx_w-1:0]    ex_csr,
    // memory stage producer
    input  wire logic [pipe_pkg::reg_idx_w-1:0]    me_rd,
    input  wire logic [pipe_pkg::csr_idx_w-1:0]    me_csr_rd,
    input  wire logic                              me_write_gpr,
    input  wire logic                              me_write_csr,
    input  wire logic                              me_mem_to_reg,
    input  wire logic [pipe_pkg::xlen-1:0]         me_rdata,
    input  wire logic [pipe_pkg::xlen-1:0]         me_alu_out,
    input  wire logic [pipe_pkg::xlen-1:0]         me_csr_out,
    // writeback stage producer
    input  wire logic [pipe_pkg::reg_idx_w-1:0]    wb_rd_idx,
    input  wire logic [pipe_pkg::csr_idx_w-1:0]    wb_csr_rd,
    input  wire logic                              wb_write_gpr,
    input  wire logic                              wb_write_csr,
    input  wire logic [pipe_pkg::xlen-1:0]         wb_gpr_data,
    input  wire logic [pipe_pkg::xlen-1:0]         wb_csr_data,
    // pipeline control
    output logic                                   stall_pipe,
    output logic                                   flush_mem,
    // execute forwarding
    output logic [pipe_pkg::xlen-1:0]              ex_rs1_data,
    output logic [pipe_pkg::xlen-1:0]              ex_rs2_data,
    output logic [pipe_pkg::xlen-1:0]              ex_csr_data,
    output logic                                   ex_rs1_fwd,
    output logic                                   ex_rs2_fwd,
    output logic                                   ex_csr_fwd,
    // decode forwarding into the decode/execute register
    output logic [pipe_pkg::xlen-1:0]              id_rs1_data,
    output logic [pipe_pkg::xlen-1:0]              id_rs2_data,
    output logic [pipe_pkg::xlen-1:0]              id_csr_data,
    output logic                                   id_rs1_fwd,
    output logic                                   id_rs2_fwd,
    output logic                                   id_csr_fwd
);

    logic first_rs1, first_rs2, first_csr;
    logic load_rs1, load_rs2;
    logic second_rs1, second_rs2, second_csr;
    logic process_over;

    // ==============================
    // hazard classes
    // ==============================

    // first stage: memory-stage alu result feeds execute
    assign first_rs1  = (ex_rs1 == me_rd) & me_write_gpr & ~me_mem_to_reg;
    assign first_rs2  = (ex_rs2 == me_rd) & me_write_gpr & ~me_mem_to_reg;
    // a CSR producer is always csrrw, never a load
    assign first_csr  = (ex_csr == me_csr_rd) & me_write_csr;

    // load-use: memory read data goes straight to execute, no stall
    assign load_rs1   = (ex_rs1 == me_rd) & me_write_gpr & me_mem_to_reg;
    assign load_rs2   = (ex_rs2 == me_rd) & me_write_gpr & me_mem_to_reg;

    // second stage: writeback not yet in the register file
    assign second_rs1 = (ex_rs1 == wb_rd_idx) & wb_write_gpr;
    assign second_rs2 = (ex_rs2 == wb_rd_idx) & wb_write_gpr;
    assign second_csr = (ex_csr == wb_csr_rd) & wb_write_csr;

    // third stage: decode reads what writeback writes this cycle
    assign id_rs1_fwd = (id_rs1 == wb_rd_idx) & wb_write_gpr;
    assign id_rs2_fwd = (id_rs2 == wb_rd_idx) & wb_write_gpr;
    assign id_csr_fwd = (id_csr == wb_csr_rd) & wb_write_csr;

    assign id_rs1_data = wb_gpr_data;
    assign id_rs2_data = wb_gpr_data;
    assign id_csr_data = wb_csr_data;

    // freeze everything until source and memory are ready
    assign process_over = inst_valid & mem_rvalid & mem_wready;
    assign stall_pipe   = ~process_over;
    assign flush_mem    = ~process_over;

    // ==============================
    // execute forwarding, youngest producer first
    // ==============================

    assign ex_rs1_fwd = first_rs1 | load_rs1 | second_rs1;
    assign ex_rs2_fwd = first_rs2 | load_rs2 | second_rs2;
    assign ex_csr_fwd = first_csr | second_csr;

    assign ex_rs1_data = load_rs1  ? me_rdata    :
                         first_rs1 ? me_alu_out  : wb_gpr_data;
    assign ex_rs2_data = load_rs2  ? me_rdata    :
                         first_rs2 ? me_alu_out  : wb_gpr_data;
    assign ex_csr_data = first_csr ? me_csr_out  : wb_csr_data;

endmodule

`default_nettype wire

//--- src/pipe_core.sv
// top level of the operand-delivery pipeline
// decode, three stage registers, forwarding unit, register files
// execute datapath, data memory port and writeback outputs
`timescale 1ns/1ns
`default_nettype none

module pipe_core (
    input  wire logic                              clk,
    input  wire logic                              rst,
    // decoded instruction stream
    input  wire logic                              inst_valid,
    input  wire pipe_pkg::op_t                     inst_op,
    input  wire logic [pipe_pkg::reg_idx_w-1:0]    inst_rd,
    input  wire logic [pipe_pkg::reg_idx_w-1:0]    inst_rs1,
    input  wire logic [pipe_pkg::reg_idx_w-1:0]    inst_rs2,
    input  wire logic [pipe_pkg::csr_idx_w-1:0]    inst_csr,
    input  wire logic [pipe_pkg::xlen-1:0]         inst_imm,
    // data memory
    input  wire logic [pipe_pkg::xlen-1:0]         mem_rdata,
    input  wire logic                              mem_rvalid,
    input  wire logic                              mem_wready,
    output logic                                   stall,
    output logic [pipe_pkg::xlen-1:0]              mem_addr,
    output logic [pipe_pkg::xlen-1:0]              mem_wdata,
    output logic                                   mem_we,
    // retirement
    output logic                                   wb_valid,
    output logic [pipe_pkg::reg_idx_w-1:0]         wb_rd,
    output logic [pipe_pkg::xlen-1:0]              wb_data
);

    pipe_pkg::id_ex_t  id_ex_d, id_ex_q;
    pipe_pkg::ex_mem_t ex_mem_d, ex_mem_q;
    pipe_pkg::mem_wb_t mem_wb_d, mem_wb_q;

    logic                      flush_mem;
    logic                      dec_writes_gpr;
    logic [pipe_pkg::xlen-1:0] rf_rs1_val, rf_rs2_val, rf_csr_val;
    logic [pipe_pkg::xlen-1:0] id_rs1_data, id_rs2_data, id_csr_data;
    logic                      id_rs1_fwd, id_rs2_fwd, id_csr_fwd;
    logic [pipe_pkg::xlen-1:0] ex_rs1_data, ex_rs2_data, ex_csr_data;
    logic                      ex_rs1_fwd, ex_rs2_fwd, ex_csr_fwd;
    logic [pipe_pkg::xlen-1:0] op_a, op_b, op_csr;
    logic [pipe_pkg::xlen-1:0] alu_out, csr_out;

    // ==============================
    // decode
    // ==============================

    always_comb begin
        case (inst_op)
            pipe_pkg::op_add, pipe_pkg::op_sub, pipe_pkg::op_addi,
            pipe_pkg::op_and, pipe_pkg::op_or, pipe_pkg::op_xor,
            pipe_pkg::op_lw, pipe_pkg::op_csrrw: dec_writes_gpr = 1'b1;
            default: dec_writes_gpr = 1'b0;
        endcase
    end

    arch_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .rs1        (inst_rs1),
        .rs2        (inst_rs2),
        .csr_rd_idx (inst_csr),
        .we_gpr     (mem_wb_q.valid & mem_wb_q.write_gpr),
        .wd_idx     (mem_wb_q.rd),
        .wd_gpr     (mem_wb_q.gpr_data),
        .we_csr     (mem_wb_q.valid & mem_wb_q.write_csr),
        .wc_idx     (mem_wb_q.csr),
        .wd_csr     (mem_wb_q.csr_data),
        .rs1_val    (rf_rs1_val),
        .rs2_val    (rf_rs2_val),
        .csr_val    (rf_csr_val)
    );

    always_comb begin
        id_ex_d = id_ex_q;
        if (stall) begin
            // frozen slot keeps its instruction but picks up the resolved
            // operands, since the writeback producer retires during the stall
            id_ex_d.rs1_val = op_a;
            id_ex_d.rs2_val = op_b;
            id_ex_d.csr_val = op_csr;
        end else begin
            id_ex_d.valid      = inst_valid;
            id_ex_d.op         = inst_op;
            id_ex_d.rd         = inst_rd;
            id_ex_d.rs1        = inst_rs1;
            id_ex_d.rs2        = inst_rs2;
            id_ex_d.csr        = inst_csr;
            id_ex_d.imm        = inst_imm;
            // x0 never produces, so no zero check in forwarding
            id_ex_d.write_gpr  = dec_writes_gpr && (inst_rd != '0);
            id_ex_d.write_csr  = (inst_op == pipe_pkg::op_csrrw);
            id_ex_d.mem_to_reg = (inst_op == pipe_pkg::op_lw);
            id_ex_d.rs1_val    = id_rs1_fwd ? id_rs1_data : rf_rs1_val;
            id_ex_d.rs2_val    = id_rs2_fwd ? id_rs2_data : rf_rs2_val;
            id_ex_d.csr_val    = id_csr_fwd ? id_csr_data : rf_csr_val;
        end
    end

    stage_reg #(.payload_t(pipe_pkg::id_ex_t)) u_id_ex (
        .clk    (clk),
        .rst    (rst),
        .hold   (1'b0),
        .bubble (1'b0),
        .d      (id_ex_d),
        .q      (id_ex_q)
    );

    // ==============================
    // execute
    // ==============================

    forward_unit u_forward (
        .inst_valid    (inst_valid),
        .mem_rvalid    (mem_rvalid),
        .mem_wready    (mem_wready),
        .id_rs1        (inst_rs1),
        .id_rs2        (inst_rs2),
        .id_csr        (inst_csr),
        .ex_rs1        (id_ex_q.rs1),
        .ex_rs2        (id_ex_q.rs2),
        .ex_csr        (id_ex_q.csr),
        .me_rd         (ex_mem_q.rd),
        .me_csr_rd     (ex_mem_q.csr),
        .me_write_gpr  (ex_mem_q.valid & ex_mem_q.write_gpr),
        .me_write_csr  (ex_mem_q.valid & ex_mem_q.write_csr),
        .me_mem_to_reg (ex_mem_q.mem_to_reg),
        .me_rdata      (mem_rdata),
        .me_alu_out    (ex_mem_q.alu_out),
        .me_csr_out    (ex_mem_q.csr_out),
        .wb_rd_idx     (mem_wb_q.rd),
        .wb_csr_rd     (mem_wb_q.csr),
        .wb_write_gpr  (mem_wb_q.valid & mem_wb_q.write_gpr),
        .wb_write_csr  (mem_wb_q.valid & mem_wb_q.write_csr),
        .wb_gpr_data   (mem_wb_q.gpr_data),
        .wb_csr_data   (mem_wb_q.csr_data),
        .stall_pipe    (stall),
        .flush_mem     (flush_mem),
        .ex_rs1_data   (ex_rs1_data),
        .ex_rs2_data   (ex_rs2_data),
        .ex_csr_data   (ex_csr_data),
        .ex_rs1_fwd    (ex_rs1_fwd),
        .ex_rs2_fwd    (ex_rs2_fwd),
        .ex_csr_fwd    (ex_csr_fwd),
        .id_rs1_data   (id_rs1_data),
        .id_rs2_data   (id_rs2_data),
        .id_csr_data   (id_csr_data),
        .id_rs1_fwd    (id_rs1_fwd),
        .id_rs2_fwd    (id_rs2_fwd),
        .id_csr_fwd    (id_csr_fwd)
    );

    assign op_a   = ex_rs1_fwd ? ex_rs1_data : id_ex_q.rs1_val;
    assign op_b   = ex_rs2_fwd ? ex_rs2_data : id_ex_q.rs2_val;
    assign op_csr = ex_csr_fwd ? ex_csr_data : id_ex_q.csr_val;

    exec_alu u_alu (
        .op      (id_ex_q.op),
        .a       (op_a),
        .b       (op_b),
        .imm     (id_ex_q.imm),
        .csr_in  (op_csr),
        .alu_out (alu_out),
        .csr_out (csr_out)
    );

    always_comb begin
        ex_mem_d.valid      = id_ex_q.valid;
        ex_mem_d.rd         = id_ex_q.rd;
        ex_mem_d.csr        = id_ex_q.csr;
        ex_mem_d.write_gpr  = id_ex_q.write_gpr;
        ex_mem_d.write_csr  = id_ex_q.write_csr;
        ex_mem_d.mem_to_reg = id_ex_q.mem_to_reg;
        ex_mem_d.is_store   = (id_ex_q.op == pipe_pkg::op_sw);
        ex_mem_d.alu_out    = alu_out;
        ex_mem_d.csr_out    = csr_out;
        ex_mem_d.store_data = op_b;
    end

    stage_reg #(.payload_t(pipe_pkg::ex_mem_t)) u_ex_mem (
        .clk    (clk),
        .rst    (rst),
        .hold   (stall),
        .bubble (1'b0),
        .d      (ex_mem_d),
        .q      (ex_mem_q)
    );

    // ==============================
    // memory and writeback
    // ==============================

    assign mem_addr  = ex_mem_q.alu_out;
    assign mem_wdata = ex_mem_q.store_data;
    assign mem_we    = ex_mem_q.valid & ex_mem_q.is_store;

    always_comb begin
        mem_wb_d.valid     = ex_mem_q.valid;
        mem_wb_d.rd        = ex_mem_q.rd;
        mem_wb_d.csr       = ex_mem_q.csr;
        mem_wb_d.write_gpr = ex_mem_q.write_gpr;
        mem_wb_d.write_csr = ex_mem_q.write_csr;
        mem_wb_d.gpr_data  = ex_mem_q.mem_to_reg ? mem_rdata : ex_mem_q.alu_out;
        mem_wb_d.csr_data  = ex_mem_q.csr_out;
    end

    // bubble while frozen so each instruction retires once
    stage_reg #(.payload_t(pipe_pkg::mem_wb_t)) u_mem_wb (
        .clk    (clk),
        .rst    (rst),
        .hold   (1'b0),
        .bubble (flush_mem),
        .d      (mem_wb_d),
        .q      (mem_wb_q)
    );

    assign wb_valid = mem_wb_q.valid & mem_wb_q.write_gpr;
    assign wb_rd    = mem_wb_q.rd;
    assign wb_data  = mem_wb_q.gpr_data;

endmodule

`default_nettype wire

//--- src/pipe_pkg.sv
// shared definitions for the operand-delivery pipeline
// widths, operation codes, stage payload structs
`default_nettype none

package pipe_pkg;

    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;
    localparam int csr_idx_w = 2;

    // decoded operations, nop must stay zero
    typedef enum logic [3:0] {
        op_nop   = 4'd0,
        op_add   = 4'd1,
        op_sub   = 4'd2,
        op_addi  = 4'd3,
        op_and   = 4'd4,
        op_or    = 4'd5,
        op_xor   = 4'd6,
        op_lw    = 4'd7,
        op_sw    = 4'd8,
        op_csrrw = 4'd9
    } op_t;

    // ==============================
    // stage payloads
    // ==============================

    typedef struct packed {
        logic                 valid;
        op_t                  op;
        logic [reg_idx_w-1:0] rd;
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic [csr_idx_w-1:0] csr;
        logic [xlen-1:0]      imm;
        logic                 write_gpr;
        logic                 write_csr;
        logic                 mem_to_reg;
        logic [xlen-1:0]      rs1_val;
        logic [xlen-1:0]      rs2_val;
        logic [xlen-1:0]      csr_val;
    } id_ex_t;

    typedef struct packed {
        logic                 valid;
        logic [reg_idx_w-1:0] rd;
        logic [csr_idx_w-1:0] csr;
        logic                 write_gpr;
        logic                 write_csr;
        logic                 mem_to_reg;
        logic                 is_store;
        logic [xlen-1:0]      alu_out;
        logic [xlen-1:0]      csr_out;
        logic [xlen-1:0]      store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                 valid;
        logic [reg_idx_w-1:0] rd;
        logic [csr_idx_w-1:0] csr;
        logic                 write_gpr;
        logic                 write_csr;
        logic [xlen-1:0]      gpr_data;
        logic [xlen-1:0]      csr_data;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- src/stage_reg.sv
// generic pipeline stage register
// freeze via hold, bubble insertion clears the slot
`timescale 1ns/1ns
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     hold,
    input  wire logic     bubble,
    input  wire payload_t d,
    output payload_t      q
);

    // all-zero payload is an empty slot (valid low)
    always_ff @(posedge clk) begin
        if (rst || bubble) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire
